// File: fm_stereo_config.svh
`ifndef FM_STEREO_CONFIG_SVH
`define FM_STEREO_CONFIG_SVH

// sample and byte widths
`define FM_DATA_W 32
`define FM_BYTE_W 8

// quantization and output gain shifts
`define FM_BITS 10
`define FM_GAIN_SHIFT 4

// de-emphasis taps, quantized by FM_BITS
`define FM_IIR_X0 (32'sd178)
`define FM_IIR_X1 (32'sd178)
`define FM_IIR_Y1 (-32'sd666)

`define FM_IO_DEPTH 128
`define FM_LINK_DEPTH 8

`endif

// File: fm_stereo_pkg.sv
`default_nettype none
`include "fm_stereo_config.svh"

package fm_stereo_pkg;

    typedef logic [`FM_BYTE_W-1:0] byte_t;

    typedef logic signed [`FM_DATA_W-1:0] sample_t;

    // first is L+R or left, second is L-R or right
    typedef struct packed {
        sample_t first;
        sample_t second;
    } pair_t;

endpackage

`default_nettype wire

// File: sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  wire logic             clock,
    input  wire logic             i_arst_n,
    input  wire logic             i_wr_en,
    input  wire logic [WIDTH-1:0] i_din,
    output logic                  o_full,
    input  wire logic             i_rd_en,
    output logic      [WIDTH-1:0] o_dout,
    output logic                  o_empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_wr;
    logic             do_rd;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_full  = (count == CW'(DEPTH));
    assign o_empty = (count == '0);
    assign do_wr   = i_wr_en && !o_full;
    assign do_rd   = i_rd_en && !o_empty;

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_rd)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (do_wr)
            mem[wr_ptr] <= i_din;
        if (do_rd)
            o_dout <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

// File: sample_unpack.sv
`timescale 1ns/1ps
`default_nettype none
`include "fm_stereo_config.svh"

module sample_unpack (
    input  wire logic                 clock,
    input  wire logic                 i_arst_n,
    input  wire logic                 i_empty,
    output logic                      o_rd_en,
    input  wire fm_stereo_pkg::byte_t i_byte,
    input  wire logic                 i_full,
    output logic                      o_wr_en,
    output fm_stereo_pkg::pair_t      o_pair
);

    localparam int HALF_W = 2 * `FM_BYTE_W;
    localparam logic S_READ  = 1'b0;
    localparam logic S_WRITE = 1'b1;

    logic                      state;
    logic [1:0]                byte_cnt;
    logic                      rd_vld;
    logic [2*HALF_W-1:0]       shreg;

    // reads may run back to back, the last byte lands in the first write cycle
    assign o_rd_en = (state == S_READ) && !i_empty;
    assign o_wr_en = (state == S_WRITE) && !rd_vld && !i_full;

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= S_READ;
            byte_cnt <= '0;
            rd_vld   <= 1'b0;
        end else begin
            rd_vld <= o_rd_en;
            if (o_rd_en)
                byte_cnt <= byte_cnt + 1'b1;
            if (o_rd_en && byte_cnt == 2'd3)
                state <= S_WRITE;
            else if (o_wr_en)
                state <= S_READ;
        end
    end

    // lsb first, byte 0 ends up at the bottom
    always_ff @(posedge clock) begin
        if (rd_vld)
            shreg <= {i_byte, shreg[2*HALF_W-1:`FM_BYTE_W]};
    end

    always_comb begin
        o_pair.first  = fm_stereo_pkg::sample_t'($signed(shreg[HALF_W-1:0])) <<< `FM_BITS;
        o_pair.second = fm_stereo_pkg::sample_t'($signed(shreg[2*HALF_W-1:HALF_W])) <<< `FM_BITS;
    end

endmodule

`default_nettype wire

// File: stereo_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module stereo_matrix (
    input  wire logic                 clock,
    input  wire logic                 i_arst_n,
    input  wire logic                 i_empty,
    output logic                      o_rd_en,
    input  wire fm_stereo_pkg::pair_t i_pair,
    input  wire logic                 i_full,
    output logic                      o_wr_en,
    output fm_stereo_pkg::pair_t      o_pair
);

    localparam logic S_READ  = 1'b0;
    localparam logic S_WRITE = 1'b1;

    logic state;
    logic rd_vld;

    assign o_rd_en = (state == S_READ) && !i_empty;
    assign o_wr_en = (state == S_WRITE) && !rd_vld && !i_full;

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state  <= S_READ;
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= o_rd_en;
            if (o_rd_en)
                state <= S_WRITE;
            else if (o_wr_en)
                state <= S_READ;
        end
    end

    // left = lpr + lmr, right = lpr - lmr
    always_ff @(posedge clock) begin
        if (rd_vld) begin
            o_pair.first  <= i_pair.first + i_pair.second;
            o_pair.second <= i_pair.first - i_pair.second;
        end
    end

endmodule

`default_nettype wire

// File: deemph_iir.sv
`timescale 1ns/1ps
`default_nettype none
`include "fm_stereo_config.svh"

module deemph_iir (
    input  wire logic                 clock,
    input  wire logic                 i_arst_n,
    input  wire logic                 i_empty,
    output logic                      o_rd_en,
    input  wire fm_stereo_pkg::pair_t i_pair,
    input  wire logic                 i_full,
    output logic                      o_wr_en,
    output fm_stereo_pkg::pair_t      o_pair
);

    localparam logic S_READ  = 1'b0;
    localparam logic S_WRITE = 1'b1;

    logic                 state;
    logic                 rd_vld;
    fm_stereo_pkg::pair_t x_prev;
    fm_stereo_pkg::pair_t y_prev;

    // one step of the first order recurrence, products wrap at 32 bits
    function automatic fm_stereo_pkg::sample_t step(
        input fm_stereo_pkg::sample_t x,
        input fm_stereo_pkg::sample_t x1,
        input fm_stereo_pkg::sample_t y1
    );
        fm_stereo_pkg::sample_t acc_x;
        fm_stereo_pkg::sample_t acc_y;
        acc_x = `FM_IIR_X0 * x + `FM_IIR_X1 * x1;
        acc_y = `FM_IIR_Y1 * y1;
        return (acc_x >>> `FM_BITS) + (acc_y >>> `FM_BITS);
    endfunction

    assign o_rd_en = (state == S_READ) && !i_empty;
    assign o_wr_en = (state == S_WRITE) && !rd_vld && !i_full;

    // history moves on the write, i_pair is still the fetched word then
    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state  <= S_READ;
            rd_vld <= 1'b0;
            x_prev <= '0;
            y_prev <= '0;
        end else begin
            rd_vld <= o_rd_en;
            if (o_rd_en) begin
                state <= S_WRITE;
            end else if (o_wr_en) begin
                state  <= S_READ;
                x_prev <= i_pair;
                y_prev <= o_pair;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rd_vld) begin
            o_pair.first  <= step(i_pair.first, x_prev.first, y_prev.first);
            o_pair.second <= step(i_pair.second, x_prev.second, y_prev.second);
        end
    end

endmodule

`default_nettype wire

// File: volume_gain.sv
`timescale 1ns/1ps
`default_nettype none
`include "fm_stereo_config.svh"

module volume_gain (
    input  wire logic                   clock,
    input  wire logic                   i_arst_n,
    input  wire fm_stereo_pkg::sample_t i_volume,
    input  wire logic                   i_empty,
    output logic                        o_rd_en,
    input  wire fm_stereo_pkg::pair_t   i_pair,
    input  wire logic                   i_full,
    output logic                        o_wr_en,
    output fm_stereo_pkg::sample_t      o_left,
    output fm_stereo_pkg::sample_t      o_right
);

    localparam logic S_READ  = 1'b0;
    localparam logic S_WRITE = 1'b1;

    logic state;
    logic rd_vld;

    function automatic fm_stereo_pkg::sample_t scale(
        input fm_stereo_pkg::sample_t x,
        input fm_stereo_pkg::sample_t vol
    );
        fm_stereo_pkg::sample_t prod;
        prod = x * vol;
        return (prod >>> `FM_BITS) <<< `FM_GAIN_SHIFT;
    endfunction

    // i_full is the or of both output fifos
    assign o_rd_en = (state == S_READ) && !i_empty;
    assign o_wr_en = (state == S_WRITE) && !rd_vld && !i_full;

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state  <= S_READ;
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= o_rd_en;
            if (o_rd_en)
                state <= S_WRITE;
            else if (o_wr_en)
                state <= S_READ;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_vld) begin
            o_left  <= scale(i_pair.first, i_volume);
            o_right <= scale(i_pair.second, i_volume);
        end
    end

endmodule

`default_nettype wire

// File: fm_stereo_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fm_stereo_config.svh"

module fm_stereo_top (
    input  wire logic                   clock,
    input  wire logic                   i_arst_n,
    input  wire logic                   i_in_wr_en,
    input  wire fm_stereo_pkg::byte_t   i_in_din,
    output logic                        o_in_full,
    input  wire fm_stereo_pkg::sample_t i_volume,
    input  wire logic                   i_left_rd_en,
    output fm_stereo_pkg::sample_t      o_left_data,
    output logic                        o_left_empty,
    input  wire logic                   i_right_rd_en,
    output fm_stereo_pkg::sample_t      o_right_data,
    output logic                        o_right_empty
);

    localparam int PAIR_W = $bits(fm_stereo_pkg::pair_t);

    fm_stereo_pkg::byte_t   in_dout;
    logic                   in_rd_en;
    logic                   in_empty;

    fm_stereo_pkg::pair_t   mux_din;
    fm_stereo_pkg::pair_t   mux_dout;
    logic                   mux_wr_en;
    logic                   mux_full;
    logic                   mux_rd_en;
    logic                   mux_empty;

    fm_stereo_pkg::pair_t   mix_din;
    fm_stereo_pkg::pair_t   mix_dout;
    logic                   mix_wr_en;
    logic                   mix_full;
    logic                   mix_rd_en;
    logic                   mix_empty;

    fm_stereo_pkg::pair_t   dmp_din;
    fm_stereo_pkg::pair_t   dmp_dout;
    logic                   dmp_wr_en;
    logic                   dmp_full;
    logic                   dmp_rd_en;
    logic                   dmp_empty;

    fm_stereo_pkg::sample_t left_din;
    fm_stereo_pkg::sample_t right_din;
    logic                   out_wr_en;
    logic                   left_full;
    logic                   right_full;
    logic                   out_full;

    // both channels are written together, so either one full stalls the pair
    assign out_full = left_full || right_full;

    sync_fifo #(.WIDTH(`FM_BYTE_W), .DEPTH(`FM_IO_DEPTH)) fifo_in_inst (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(i_in_wr_en), .i_din(i_in_din), .o_full(o_in_full),
        .i_rd_en(in_rd_en), .o_dout(in_dout), .o_empty(in_empty)
    );

    sample_unpack unpack_inst (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_empty(in_empty), .o_rd_en(in_rd_en), .i_byte(in_dout),
        .i_full(mux_full), .o_wr_en(mux_wr_en), .o_pair(mux_din)
    );

    sync_fifo #(.WIDTH(PAIR_W), .DEPTH(`FM_LINK_DEPTH)) fifo_mux_inst (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(mux_wr_en), .i_din(mux_din), .o_full(mux_full),
        .i_rd_en(mux_rd_en), .o_dout(mux_dout), .o_empty(mux_empty)
    );

    stereo_matrix matrix_inst (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_empty(mux_empty), .o_rd_en(mux_rd_en), .i_pair(mux_dout),
        .i_full(mix_full), .o_wr_en(mix_wr_en), .o_pair(mix_din)
    );

    sync_fifo #(.WIDTH(PAIR_W), .DEPTH(`FM_LINK_DEPTH)) fifo_mix_inst (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(mix_wr_en), .i_din(mix_din), .o_full(mix_full),
        .i_rd_en(mix_rd_en), .o_dout(mix_dout), .o_empty(mix_empty)
    );

    deemph_iir deemph_inst (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_empty(mix_empty), .o_rd_en(mix_rd_en), .i_pair(mix_dout),
        .i_full(dmp_full), .o_wr_en(dmp_wr_en), .o_pair(dmp_din)
    );

    sync_fifo #(.WIDTH(PAIR_W), .DEPTH(`FM_LINK_DEPTH)) fifo_dmp_inst (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(dmp_wr_en), .i_din(dmp_din), .o_full(dmp_full),
        .i_rd_en(dmp_rd_en), .o_dout(dmp_dout), .o_empty(dmp_empty)
    );

    volume_gain gain_inst (
        .clock(clock), .i_arst_n(i_arst_n), .i_volume(i_volume),
        .i_empty(dmp_empty), .o_rd_en(dmp_rd_en), .i_pair(dmp_dout),
        .i_full(out_full), .o_wr_en(out_wr_en),
        .o_left(left_din), .o_right(right_din)
    );

    sync_fifo #(.WIDTH(`FM_DATA_W), .DEPTH(`FM_IO_DEPTH)) fifo_left_inst (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(out_wr_en), .i_din(left_din), .o_full(left_full),
        .i_rd_en(i_left_rd_en), .o_dout(o_left_data), .o_empty(o_left_empty)
    );

    sync_fifo #(.WIDTH(`FM_DATA_W), .DEPTH(`FM_IO_DEPTH)) fifo_right_inst (
        .clock(clock), .i_arst_n(i_arst_n),
        .i_wr_en(out_wr_en), .i_din(right_din), .o_full(right_full),
        .i_rd_en(i_right_rd_en), .o_dout(o_right_data), .o_empty(o_right_empty)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 20
) (
    output logic o_clock
);

    initial o_clock = 1'b0;

    always #(PERIOD / 2) o_clock = ~o_clock;

endmodule

`default_nettype wire

// File: fm_stereo_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fm_stereo_properties (
    input wire logic clock,
    input wire logic i_arst_n,
    input wire logic i_wr_en,
    input wire logic i_rd_en,
    input wire logic i_full,
    input wire logic i_empty
);

    flags_exclusive: assert property (@(posedge clock) disable iff (!i_arst_n)
        !(i_full && i_empty))
        else $error("fifo reports full and empty at once");

    // a write into a full fifo is dropped, so it stays full
    no_write_when_full: assert property (@(posedge clock) disable iff (!i_arst_n)
        (i_full && i_wr_en && !i_rd_en) |=> i_full)
        else $error("fifo accepted a write while full");

    no_read_when_empty: assert property (@(posedge clock) disable iff (!i_arst_n)
        (i_empty && i_rd_en && !i_wr_en) |=> i_empty)
        else $error("fifo accepted a read while empty");

endmodule

bind sync_fifo fm_stereo_properties props_inst (
    .clock(clock), .i_arst_n(i_arst_n), .i_wr_en(i_wr_en), .i_rd_en(i_rd_en),
    .i_full(o_full), .i_empty(o_empty)
);

`default_nettype wire

// File: fm_stereo_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fm_stereo_config.svh"

module fm_stereo_tb;

    localparam int MODE_STREAM = 0;
    localparam int MODE_HOLD   = 1;
    localparam int MODE_SPLIT  = 2;
    localparam int HOLD_GROUPS = 256;
    localparam int TOTAL_BYTES = 4 * (1 + 16 + 3 * 16 + HOLD_GROUPS + 24);
    localparam int CYCLE_LIMIT = 8 * TOTAL_BYTES + 1000;

    logic                   clock;
    logic                   arst_n;
    logic                   in_wr_en;
    fm_stereo_pkg::byte_t   in_din;
    logic                   in_full;
    fm_stereo_pkg::sample_t volume;
    logic                   left_rd_en;
    fm_stereo_pkg::sample_t left_data;
    logic                   left_empty;
    logic                   right_rd_en;
    fm_stereo_pkg::sample_t right_data;
    logic                   right_empty;

    fm_stereo_pkg::byte_t   byte_q[$];
    fm_stereo_pkg::sample_t exp_left[$];
    fm_stereo_pkg::sample_t exp_right[$];
    // filter history, index 0 is left and 1 is right
    fm_stereo_pkg::sample_t x_hist[2];
    fm_stereo_pkg::sample_t y_hist[2];
    int                     cycles;

    tb_clock_gen #(.PERIOD(20)) clk_gen (.o_clock(clock));

    fm_stereo_top dut (
        .clock(clock), .i_arst_n(arst_n),
        .i_in_wr_en(in_wr_en), .i_in_din(in_din), .o_in_full(in_full),
        .i_volume(volume),
        .i_left_rd_en(left_rd_en), .o_left_data(left_data), .o_left_empty(left_empty),
        .i_right_rd_en(right_rd_en), .o_right_data(right_data),
        .o_right_empty(right_empty)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT)
            report_failure("timeout: the outputs stopped delivering samples");
    end

    function automatic fm_stereo_pkg::sample_t wrap32(input longint v);
        return v[31:0];
    endfunction

    function automatic fm_stereo_pkg::sample_t dequant(input fm_stereo_pkg::sample_t v);
        return v >>> `FM_BITS;
    endfunction

    function automatic fm_stereo_pkg::sample_t deemph_step(
        input int ch,
        input fm_stereo_pkg::sample_t x
    );
        fm_stereo_pkg::sample_t y;
        y = dequant(wrap32(longint'(`FM_IIR_X0) * x + longint'(`FM_IIR_X1) * x_hist[ch]))
            + dequant(wrap32(longint'(`FM_IIR_Y1) * y_hist[ch]));
        x_hist[ch] = x;
        y_hist[ch] = y;
        return y;
    endfunction

    function automatic fm_stereo_pkg::sample_t apply_volume(input fm_stereo_pkg::sample_t v);
        return dequant(wrap32(longint'(v) * longint'(volume))) <<< `FM_GAIN_SHIFT;
    endfunction

    // model of one four byte group, lsb first
    task automatic queue_group(input fm_stereo_pkg::byte_t b0, input fm_stereo_pkg::byte_t b1,
                               input fm_stereo_pkg::byte_t b2, input fm_stereo_pkg::byte_t b3);
        logic signed [15:0]     sum_word;
        logic signed [15:0]     diff_word;
        fm_stereo_pkg::sample_t lpr;
        fm_stereo_pkg::sample_t lmr;
        sum_word  = {b1, b0};
        diff_word = {b3, b2};
        lpr = sum_word * (2 ** `FM_BITS);
        lmr = diff_word * (2 ** `FM_BITS);
        byte_q.push_back(b0);
        byte_q.push_back(b1);
        byte_q.push_back(b2);
        byte_q.push_back(b3);
        exp_left.push_back(apply_volume(deemph_step(0, lpr + lmr)));
        exp_right.push_back(apply_volume(deemph_step(1, lpr - lmr)));
    endtask

    task automatic queue_random(input int n);
        for (int i = 0; i < n; i++)
            queue_group($urandom_range(255), $urandom_range(255),
                        $urandom_range(255), $urandom_range(255));
    endtask

    task automatic apply_reset();
        @(posedge clock);
        #1 arst_n = 1'b0;
        x_hist = '{0, 0};
        y_hist = '{0, 0};
        repeat (2) @(posedge clock);
        #1 arst_n = 1'b1;
    endtask

    task automatic check_value(input string ch, input int idx,
                               input fm_stereo_pkg::sample_t got,
                               input fm_stereo_pkg::sample_t exp);
        assert (got === exp) else
            report_failure($sformatf("[ERROR] %0d ns: %s sample %0d is %0d, expected %0d",
                                     $time, ch, idx, got, exp));
    endtask

    // writes the byte queue and reads both outputs, one cycle at a time
    task automatic run_stream(input int mode);
        int   n;
        int   idx;
        int   left_cnt;
        int   right_cnt;
        logic left_pend;
        logic right_pend;
        logic full_seen;
        n = exp_left.size();
        idx = 0;
        left_cnt = 0;
        right_cnt = 0;
        left_pend = 1'b0;
        right_pend = 1'b0;
        full_seen = 1'b0;
        while (left_cnt < n || right_cnt < n) begin
            @(posedge clock);
            #1;
            if (left_pend) begin
                check_value("left", left_cnt, left_data, exp_left.pop_front());
                left_cnt++;
            end
            if (right_pend) begin
                check_value("right", right_cnt, right_data, exp_right.pop_front());
                right_cnt++;
            end
            if (in_full)
                full_seen = 1'b1;
            // strobes also hit full and empty FIFOs
            in_wr_en = (idx < byte_q.size());
            if (in_wr_en)
                in_din = byte_q[idx];
            if (in_wr_en && !in_full)
                idx++;
            left_rd_en  = (mode != MODE_HOLD || full_seen);
            right_rd_en = (mode != MODE_HOLD || full_seen)
                          && (mode != MODE_SPLIT || left_cnt == n);
            left_pend  = left_rd_en && !left_empty;
            right_pend = right_rd_en && !right_empty;
        end
        in_wr_en = 1'b0;
        left_rd_en = 1'b0;
        right_rd_en = 1'b0;
        byte_q.delete();
        assert (left_empty && right_empty) else
            report_failure("outputs hold more samples than bytes were sent for");
        if (mode == MODE_HOLD)
            assert (full_seen) else
                report_failure("input FIFO never reported full with outputs unread");
    endtask

    task automatic test_reset_state();
        assert (!in_full && left_empty && right_empty) else
            report_failure("FIFO flags are wrong after reset");
    endtask

    task automatic test_single_group();
        volume = 1024;
        queue_group(8'h34, 8'h12, 8'h0d, 8'hf0);
        run_stream(MODE_STREAM);
    endtask

    task automatic test_iir_memory();
        queue_random(16);
        run_stream(MODE_STREAM);
    endtask

    task automatic test_volumes();
        fm_stereo_pkg::sample_t vols[3];
        vols = '{512, 3000, -1500};
        foreach (vols[i]) begin
            apply_reset();
            volume = vols[i];
            queue_random(16);
            run_stream(MODE_STREAM);
        end
    endtask

    task automatic test_backpressure();
        apply_reset();
        volume = 1024;
        queue_random(HOLD_GROUPS);
        run_stream(MODE_HOLD);
    endtask

    task automatic test_split_reads();
        queue_random(24);
        run_stream(MODE_SPLIT);
    endtask

    initial begin
        void'($urandom(27646));
        cycles = 0;
        arst_n = 1'b0;
        in_wr_en = 1'b0;
        in_din = '0;
        volume = 1024;
        left_rd_en = 1'b0;
        right_rd_en = 1'b0;
        apply_reset();
        test_reset_state();
        test_single_group();
        test_iir_memory();
        test_volumes();
        test_backpressure();
        test_split_reads();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: fm_stereo.f
+incdir+.
fm_stereo_pkg.sv
sync_fifo.sv
sample_unpack.sv
stereo_matrix.sv
deemph_iir.sv
volume_gain.sv
fm_stereo_top.sv
tb_clock_gen.sv
fm_stereo_properties.sv
fm_stereo_tb.sv
